/* hdl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

	localparam int instr_width = 32;
	localparam int xlen = 64;

	////////////////////
	// Major opcodes
	////////////////////

	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_imm_32 = 7'b0011011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_reg_32 = 7'b0111011;
	localparam logic [6:0] op_misc_mem = 7'b0001111;
	localparam logic [6:0] op_system = 7'b1110011;

	////////////////////
	// Funct codes
	////////////////////

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt = 7'b0100000; // Sub and arithmetic shift.
	localparam logic [6:0] f7_muldiv = 7'b0000001;

	localparam logic [2:0] f3_add = 3'd0;
	localparam logic [2:0] f3_sll = 3'd1;
	localparam logic [2:0] f3_slt = 3'd2;
	localparam logic [2:0] f3_sltu = 3'd3;
	localparam logic [2:0] f3_xor = 3'd4;
	localparam logic [2:0] f3_srl = 3'd5; // Also sra.
	localparam logic [2:0] f3_or = 3'd6;
	localparam logic [2:0] f3_and = 3'd7;

	localparam logic [2:0] f3_beq = 3'd0;
	localparam logic [2:0] f3_bne = 3'd1;
	localparam logic [2:0] f3_blt = 3'd4;
	localparam logic [2:0] f3_bge = 3'd5;
	localparam logic [2:0] f3_bltu = 3'd6;
	localparam logic [2:0] f3_bgeu = 3'd7;

	// Access width of loads and stores.
	localparam logic [2:0] f3_byte = 3'd0;
	localparam logic [2:0] f3_half = 3'd1;
	localparam logic [2:0] f3_word = 3'd2;
	localparam logic [2:0] f3_double = 3'd3;
	localparam logic [2:0] f3_byte_u = 3'd4;
	localparam logic [2:0] f3_half_u = 3'd5;
	localparam logic [2:0] f3_word_u = 3'd6;

	localparam logic [2:0] f3_mul = 3'd0;
	localparam logic [2:0] f3_mulh = 3'd1;
	localparam logic [2:0] f3_mulhsu = 3'd2;
	localparam logic [2:0] f3_mulhu = 3'd3;
	localparam logic [2:0] f3_div = 3'd4;
	localparam logic [2:0] f3_divu = 3'd5;
	localparam logic [2:0] f3_rem = 3'd6;
	localparam logic [2:0] f3_remu = 3'd7;

	localparam logic [2:0] f3_fence = 3'd0;
	localparam logic [2:0] f3_fence_i = 3'd1;
	localparam logic [2:0] f3_csrrs = 3'd2;

	localparam logic [instr_width-1:0] word_ecall = 32'h0000_0073;
	localparam logic [instr_width-1:0] word_ebreak = 32'h0010_0073;

	// Counter CSR addresses.
	localparam logic [11:0] csr_cycle = 12'hc00;
	localparam logic [11:0] csr_time = 12'hc01;
	localparam logic [11:0] csr_instret = 12'hc02;
	localparam logic [11:0] csr_cycleh = 12'hc80;
	localparam logic [11:0] csr_timeh = 12'hc81;
	localparam logic [11:0] csr_instreth = 12'hc82;

	typedef enum logic [2:0] {
		r_fmt,
		i_fmt,
		s_fmt,
		b_fmt,
		u_fmt,
		j_fmt,
		unknown_fmt
	} instr_format_t;

	////////////////////
	// Instruction word views
	////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_view_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_view_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_view_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_view_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
		s_view_t s_view;
		b_view_t b_view;
		u_view_t u_view;
		j_view_t j_view;
	} instr_word_u;

endpackage

/* hdl/decode_pkg.sv */
package decode_pkg;

	////////////////////
	// Operations
	////////////////////

	typedef enum logic [7:0] {
		op_unknown = 8'd0,
		// Base integer.
		mn_lui, mn_auipc, mn_jal, mn_jalr,
		mn_beq, mn_bne, mn_blt, mn_bge, mn_bltu, mn_bgeu,
		mn_lb, mn_lh, mn_lw, mn_ld, mn_lbu, mn_lhu, mn_lwu,
		mn_sb, mn_sh, mn_sw, mn_sd,
		mn_addi, mn_slti, mn_sltiu, mn_xori, mn_ori, mn_andi,
		mn_slli, mn_srli, mn_srai,
		mn_add, mn_sub, mn_sll, mn_slt, mn_sltu,
		mn_xor, mn_srl, mn_sra, mn_or, mn_and,
		// Word width.
		mn_addiw, mn_slliw, mn_srliw, mn_sraiw,
		mn_addw, mn_subw, mn_sllw, mn_srlw, mn_sraw,
		// M extension.
		mn_mul, mn_mulh, mn_mulhsu, mn_mulhu,
		mn_div, mn_divu, mn_rem, mn_remu,
		mn_mulw, mn_divw, mn_divuw, mn_remw, mn_remuw,
		// Fence and system.
		mn_fence, mn_fence_i, mn_scall, mn_sbreak,
		mn_rdcycle, mn_rdcycleh, mn_rdtime, mn_rdtimeh,
		mn_rdinstret, mn_rdinstreth
	} operation_t;

	typedef enum logic [3:0] {
		sk_plain = 4'b0000,   // Fence and environment calls.
		sk_counter = 4'b0001, // Counter reads.
		sk_link = 4'b0010     // Register indirect jump.
	} special_kind_t;

	typedef struct packed {
		logic load;
		logic memory_operand;
		logic arith_shift;
		logic special;
		logic is_signed;
		special_kind_t kind;
	} decode_flags_t;

	////////////////////
	// Decoded bundle
	////////////////////

	typedef struct packed {
		operation_t op;
		riscv_isa_pkg::instr_format_t fmt;
		decode_flags_t flags;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic rd_used;
		logic rs1_used;
		logic rs2_used;
		logic [riscv_isa_pkg::xlen-1:0] imm;
	} decoded_instr_t;

endpackage

/* hdl/instruction_classifier.sv */
`timescale 1ns/1ps

module instruction_classifier (
	input riscv_isa_pkg::instr_word_u instr,
	output decode_pkg::operation_t op,
	output riscv_isa_pkg::instr_format_t fmt,
	output decode_pkg::decode_flags_t flags
);
	import riscv_isa_pkg::*;
	import decode_pkg::*;

	logic [instr_width-1:0] raw;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic csr_read; // csrrs with rs1 of x0.

	assign raw = instr;
	assign opcode = instr.r_view.opcode;
	assign funct3 = instr.r_view.funct3;
	assign funct7 = instr.r_view.funct7;
	assign csr_read = (funct3 == f3_csrrs) && (instr.i_view.rs1 == 5'd0);

	////////////////////
	// Mnemonic match
	////////////////////

	always_comb
	begin
		op = op_unknown;
		case (opcode)
			op_lui: op = mn_lui;
			op_auipc: op = mn_auipc;
			op_jal: op = mn_jal;
			op_jalr:
				if (funct3 == 3'd0)
					op = mn_jalr;
			op_branch:
				case (funct3)
					f3_beq: op = mn_beq;
					f3_bne: op = mn_bne;
					f3_blt: op = mn_blt;
					f3_bge: op = mn_bge;
					f3_bltu: op = mn_bltu;
					f3_bgeu: op = mn_bgeu;
					default: op = op_unknown;
				endcase
			op_load:
				case (funct3)
					f3_byte: op = mn_lb;
					f3_half: op = mn_lh;
					f3_word: op = mn_lw;
					f3_double: op = mn_ld;
					f3_byte_u: op = mn_lbu;
					f3_half_u: op = mn_lhu;
					f3_word_u: op = mn_lwu;
					default: op = op_unknown;
				endcase
			op_store:
				case (funct3)
					f3_byte: op = mn_sb;
					f3_half: op = mn_sh;
					f3_word: op = mn_sw;
					f3_double: op = mn_sd;
					default: op = op_unknown;
				endcase
			op_imm:
				case (funct3)
					f3_add: op = mn_addi;
					f3_slt: op = mn_slti;
					f3_sltu: op = mn_sltiu;
					f3_xor: op = mn_xori;
					f3_or: op = mn_ori;
					f3_and: op = mn_andi;
					f3_sll:
						if (funct7[6:1] == f7_base[6:1]) // Six bit shamt.
							op = mn_slli;
					f3_srl:
						if (funct7[6:1] == f7_base[6:1])
							op = mn_srli;
						else if (funct7[6:1] == f7_alt[6:1])
							op = mn_srai;
					default: op = op_unknown;
				endcase
			op_imm_32:
				case (funct3)
					f3_add: op = mn_addiw;
					f3_sll:
						if (funct7 == f7_base)
							op = mn_slliw;
					f3_srl:
						if (funct7 == f7_base)
							op = mn_srliw;
						else if (funct7 == f7_alt)
							op = mn_sraiw;
					default: op = op_unknown;
				endcase
			op_reg:
				case ({funct7, funct3})
					{f7_base, f3_add}: op = mn_add;
					{f7_alt, f3_add}: op = mn_sub;
					{f7_base, f3_sll}: op = mn_sll;
					{f7_base, f3_slt}: op = mn_slt;
					{f7_base, f3_sltu}: op = mn_sltu;
					{f7_base, f3_xor}: op = mn_xor;
					{f7_base, f3_srl}: op = mn_srl;
					{f7_alt, f3_srl}: op = mn_sra;
					{f7_base, f3_or}: op = mn_or;
					{f7_base, f3_and}: op = mn_and;
					{f7_muldiv, f3_mul}: op = mn_mul;
					{f7_muldiv, f3_mulh}: op = mn_mulh;
					{f7_muldiv, f3_mulhsu}: op = mn_mulhsu;
					{f7_muldiv, f3_mulhu}: op = mn_mulhu;
					{f7_muldiv, f3_div}: op = mn_div;
					{f7_muldiv, f3_divu}: op = mn_divu;
					{f7_muldiv, f3_rem}: op = mn_rem;
					{f7_muldiv, f3_remu}: op = mn_remu;
					default: op = op_unknown;
				endcase
			op_reg_32:
				case ({funct7, funct3})
					{f7_base, f3_add}: op = mn_addw;
					{f7_alt, f3_add}: op = mn_subw;
					{f7_base, f3_sll}: op = mn_sllw;
					{f7_base, f3_srl}: op = mn_srlw;
					{f7_alt, f3_srl}: op = mn_sraw;
					{f7_muldiv, f3_mul}: op = mn_mulw;
					{f7_muldiv, f3_div}: op = mn_divw;
					{f7_muldiv, f3_divu}: op = mn_divuw;
					{f7_muldiv, f3_rem}: op = mn_remw;
					{f7_muldiv, f3_remu}: op = mn_remuw;
					default: op = op_unknown;
				endcase
			op_misc_mem:
				case (funct3)
					f3_fence: op = mn_fence;
					f3_fence_i: op = mn_fence_i;
					default: op = op_unknown;
				endcase
			op_system:
				if (raw == word_ecall)
					op = mn_scall;
				else if (raw == word_ebreak)
					op = mn_sbreak;
				else if (csr_read)
					case (instr.i_view.imm)
						csr_cycle: op = mn_rdcycle;
						csr_cycleh: op = mn_rdcycleh;
						csr_time: op = mn_rdtime;
						csr_timeh: op = mn_rdtimeh;
						csr_instret: op = mn_rdinstret;
						csr_instreth: op = mn_rdinstreth;
						default: op = op_unknown;
					endcase
			default: op = op_unknown;
		endcase
	end

	always_comb
	begin
		case (opcode)
			op_reg, op_reg_32: fmt = r_fmt;
			op_store: fmt = s_fmt;
			op_branch: fmt = b_fmt;
			op_lui, op_auipc: fmt = u_fmt;
			op_jal: fmt = j_fmt;
			default: fmt = i_fmt;
		endcase
		if (op == op_unknown)
			fmt = unknown_fmt;
	end

	////////////////////
	// Flags
	////////////////////

	always_comb
	begin
		flags = '0;
		flags.is_signed = 1'b1;
		flags.load = op inside {mn_lb, mn_lh, mn_lw, mn_ld, mn_lbu, mn_lhu, mn_lwu};
		flags.memory_operand = flags.load || (op inside {mn_sb, mn_sh, mn_sw, mn_sd});
		flags.arith_shift = op inside {mn_srai, mn_sra, mn_sraiw, mn_sraw};
		flags.special = op inside {mn_fence, mn_fence_i, mn_scall, mn_sbreak, mn_jalr,
			mn_rdcycle, mn_rdcycleh, mn_rdtime, mn_rdtimeh, mn_rdinstret, mn_rdinstreth};
		if (op inside {mn_rdcycle, mn_rdcycleh, mn_rdtime, mn_rdtimeh,
			mn_rdinstret, mn_rdinstreth})
			flags.kind = sk_counter;
		else if (op == mn_jalr)
			flags.kind = sk_link;
		if (op inside {mn_sltu, mn_sltiu, mn_bltu, mn_bgeu, mn_lbu, mn_lhu, mn_lwu,
			mn_mulhsu, mn_mulhu, mn_divu, mn_remu, mn_divuw, mn_remuw})
			flags.is_signed = 1'b0;
		if (op == op_unknown)
			flags = '0;
	end

endmodule

/* hdl/operand_extractor.sv */
`timescale 1ns/1ps

module operand_extractor (
	input riscv_isa_pkg::instr_word_u instr,
	input riscv_isa_pkg::instr_format_t fmt,
	output logic [4:0] rd,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic rd_used,
	output logic rs1_used,
	output logic rs2_used,
	output logic [63:0] imm
);
	import riscv_isa_pkg::*;

	always_comb
	begin
		rd = 5'd0;
		rs1 = 5'd0;
		rs2 = 5'd0;
		rd_used = 1'b0;
		rs1_used = 1'b0;
		rs2_used = 1'b0;
		imm = '0; // R format and unknown.
		case (fmt)
			r_fmt:
			begin
				rd = instr.r_view.rd;
				rs1 = instr.r_view.rs1;
				rs2 = instr.r_view.rs2;
				{rd_used, rs1_used, rs2_used} = 3'b111;
			end
			i_fmt:
			begin
				rd = instr.i_view.rd;
				rs1 = instr.i_view.rs1;
				{rd_used, rs1_used} = 2'b11;
				imm = {{(xlen-12){instr.i_view.imm[11]}}, instr.i_view.imm};
			end
			s_fmt:
			begin
				rs1 = instr.s_view.rs1;
				rs2 = instr.s_view.rs2;
				{rs1_used, rs2_used} = 2'b11;
				imm = {{(xlen-12){instr.s_view.imm_11_5[6]}},
					instr.s_view.imm_11_5, instr.s_view.imm_4_0};
			end
			b_fmt:
			begin
				rs1 = instr.b_view.rs1;
				rs2 = instr.b_view.rs2;
				{rs1_used, rs2_used} = 2'b11;
				imm = {{(xlen-13){instr.b_view.imm_12}}, instr.b_view.imm_12,
					instr.b_view.imm_11, instr.b_view.imm_10_5, instr.b_view.imm_4_1,
					1'b0}; // Halfword aligned.
			end
			u_fmt:
			begin
				rd = instr.u_view.rd;
				rd_used = 1'b1;
				imm = {{(xlen-32){instr.u_view.imm_31_12[19]}},
					instr.u_view.imm_31_12, 12'd0};
			end
			j_fmt:
			begin
				rd = instr.j_view.rd;
				rd_used = 1'b1;
				imm = {{(xlen-21){instr.j_view.imm_20}}, instr.j_view.imm_20,
					instr.j_view.imm_19_12, instr.j_view.imm_11, instr.j_view.imm_10_1,
					1'b0};
			end
			default:
				imm = '0;
		endcase
	end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input logic clk,
	input logic reset,
	input riscv_isa_pkg::instr_word_u instr,
	input logic instr_valid,
	output decode_pkg::decoded_instr_t decoded,
	output logic decoded_valid
);
	import riscv_isa_pkg::*;
	import decode_pkg::*;

	operation_t op;
	instr_format_t fmt;
	decode_flags_t flags;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic rd_used;
	logic rs1_used;
	logic rs2_used;
	logic [xlen-1:0] imm;
	decoded_instr_t bundle;

	instruction_classifier classifier_i (
		.instr(instr),
		.op(op),
		.fmt(fmt),
		.flags(flags)
	);

	operand_extractor extractor_i (
		.instr(instr),
		.fmt(fmt), // Format picks the field view.
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.rd_used(rd_used),
		.rs1_used(rs1_used),
		.rs2_used(rs2_used),
		.imm(imm)
	);

	always_comb
	begin
		bundle.op = op;
		bundle.fmt = fmt;
		bundle.flags = flags;
		bundle.rd = rd;
		bundle.rs1 = rs1;
		bundle.rs2 = rs2;
		bundle.rd_used = rd_used;
		bundle.rs1_used = rs1_used;
		bundle.rs2_used = rs2_used;
		bundle.imm = imm;
	end

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			decoded <= '0;
			decoded_valid <= 1'b0;
		end
		else
		begin
			decoded <= bundle; // One cycle after the strobe.
			decoded_valid <= instr_valid;
		end
	end

endmodule

/* dv/decode_stage_assertions.sv */
`timescale 1ns/1ps

module decode_stage_assertions (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input decode_pkg::decoded_instr_t decoded,
	input logic decoded_valid
);
	import riscv_isa_pkg::*;
	import decode_pkg::*;

	int fail_count = 0; // Read by the testbench.

	////////////////////
	// Timing
	////////////////////

	reset_clears: assert property (@(posedge clk) reset |=> !decoded_valid && decoded == '0)
	else
	begin
		$error("Output register not cleared by reset.");
		fail_count++;
	end

	strobe_to_valid: assert property (@(posedge clk) disable iff (reset)
		instr_valid |=> decoded_valid)
	else
	begin
		$error("Strobe not followed by decoded_valid one cycle later.");
		fail_count++;
	end

	idle_stays_idle: assert property (@(posedge clk) disable iff (reset)
		!instr_valid |=> !decoded_valid)
	else
	begin
		$error("decoded_valid without a strobe one cycle earlier.");
		fail_count++;
	end

	////////////////////
	// Bundle
	////////////////////

	offset_aligned: assert property (@(posedge clk)
		decoded_valid && decoded.fmt inside {b_fmt, j_fmt} |-> !decoded.imm[0])
	else
	begin
		$error("Branch or jump offset has bit 0 set.");
		fail_count++;
	end

	upper_low_clear: assert property (@(posedge clk)
		decoded_valid && decoded.fmt == u_fmt |-> decoded.imm[11:0] == 12'd0)
	else
	begin
		$error("Upper immediate has low bits set.");
		fail_count++;
	end

	unknown_empty: assert property (@(posedge clk)
		decoded_valid && decoded.op == op_unknown |-> decoded.fmt == unknown_fmt
		&& decoded.flags == '0 && !decoded.rd_used && !decoded.rs1_used && !decoded.rs2_used)
	else
	begin
		$error("Unknown word decoded with format, flags or registers.");
		fail_count++;
	end

	unused_zero: assert property (@(posedge clk) decoded_valid |->
		(decoded.rd_used || decoded.rd == 5'd0) && (decoded.rs1_used || decoded.rs1 == 5'd0)
		&& (decoded.rs2_used || decoded.rs2 == 5'd0))
	else
	begin
		$error("Unused register field is not zero.");
		fail_count++;
	end

endmodule

bind decode_stage decode_stage_assertions assertions_i (
	.clk(clk),
	.reset(reset),
	.instr_valid(instr_valid),
	.decoded(decoded),
	.decoded_valid(decoded_valid)
);

/* dv/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb;
	import riscv_isa_pkg::*;
	import decode_pkg::*;

	localparam int cycle_limit = 2000; // About four times the stimulus.

	logic clk = 1'b0;
	logic reset;
	instr_word_u instr;
	logic instr_valid;
	decoded_instr_t decoded;
	logic decoded_valid;

	int cycle_count = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_run = 0;
	int failed_tests = 0;
	int assert_seen = 0;
	logic [31:0] rnd;

	decode_stage dut_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instr_valid(instr_valid),
		.decoded(decoded),
		.decoded_valid(decoded_valid)
	);

	always #4 clk = ~clk; // 8 ns period.

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: run stopped after %0d cycles.", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////
	// Encoders
	////////////////////

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
	endfunction

	function automatic logic [63:0] sign_extend(input logic [63:0] value, input int bits);
		logic signed [63:0] shifted;
		shifted = value << (64 - bits);
		return shifted >>> (64 - bits);
	endfunction

	// Bits are load, memory operand, arith shift, special, signed.
	function automatic decode_flags_t make_flags(input logic [4:0] bits, input special_kind_t kind);
		decode_flags_t f;
		f.load = bits[4];
		f.memory_operand = bits[3];
		f.arith_shift = bits[2];
		f.special = bits[1];
		f.is_signed = bits[0];
		f.kind = kind;
		return f;
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic expect_cleared();
		decoded_instr_t cleared;
		cleared = '0;
		assert (decoded === cleared)
		else
		begin
			$display("[ERROR] %0t decoded: got %h, expected %h", $time, decoded, cleared);
			test_errors++;
		end
	endtask

	task automatic apply_word(input logic [31:0] word);
		@(posedge clk);
		#1;
		instr = word;
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		check_value("decoded_valid", 64'(decoded_valid), 64'd1);
	endtask

	task automatic finish_test(input string name);
		int seen_now;
		seen_now = dut_i.assertions_i.fail_count;
		test_errors += seen_now - assert_seen; // Bound assertion failures count too.
		assert_seen = seen_now;
		if (test_errors == 0)
			$display("[PASS] %s", name);
		else
		begin
			$display("[FAIL] %s, %0d errors", name, test_errors);
			failed_tests++;
		end
		total_errors += test_errors;
		tests_run++;
		test_errors = 0;
	endtask

	task automatic classify_case(input logic [31:0] word, input operation_t exp_op,
		input instr_format_t exp_fmt);
		apply_word(word);
		check_value("decoded.op", 64'(decoded.op), 64'(exp_op));
		check_value("decoded.fmt", 64'(decoded.fmt), 64'(exp_fmt));
	endtask

	task automatic flags_case(input logic [31:0] word, input operation_t exp_op,
		input decode_flags_t exp_flags);
		apply_word(word);
		check_value("decoded.op", 64'(decoded.op), 64'(exp_op));
		check_value("decoded.flags", 64'(decoded.flags), 64'(exp_flags));
	endtask

	task automatic imm_case(input logic [31:0] word, input logic [63:0] exp_imm);
		apply_word(word);
		check_value("decoded.imm", decoded.imm, exp_imm);
	endtask

	task automatic register_case(input logic [31:0] word, input instr_format_t fmt,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [2:0] used;
		case (fmt)
			r_fmt: used = 3'b111;
			i_fmt: used = 3'b110;
			s_fmt, b_fmt: used = 3'b011;
			u_fmt, j_fmt: used = 3'b100;
			default: used = 3'b000;
		endcase
		apply_word(word);
		check_value("decoded.fmt", 64'(decoded.fmt), 64'(fmt));
		check_value("decoded.used", 64'({decoded.rd_used, decoded.rs1_used, decoded.rs2_used}),
			64'(used));
		check_value("decoded.rd", 64'(decoded.rd), used[2] ? 64'(rd) : 64'd0);
		check_value("decoded.rs1", 64'(decoded.rs1), used[1] ? 64'(rs1) : 64'd0);
		check_value("decoded.rs2", 64'(decoded.rs2), used[0] ? 64'(rs2) : 64'd0);
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic reset_latency_test();
		int k;
		@(posedge clk);
		#1;
		instr = r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, op_reg);
		instr_valid = 1'b1; // Strobe inside reset is ignored.
		@(posedge clk);
		#1;
		check_value("decoded_valid", 64'(decoded_valid), 64'd0);
		expect_cleared();
		@(posedge clk);
		#1;
		reset = 1'b0;
		instr_valid = 1'b0;
		check_value("decoded_valid", 64'(decoded_valid), 64'd0); // First cycle after reset.
		expect_cleared();
		@(posedge clk);
		#1;
		check_value("decoded_valid", 64'(decoded_valid), 64'd0);
		for (k = 0; k < 6; k++)
		begin
			instr = i_word(12'(k + 1), 5'd1, 3'd0, 5'd2, op_imm);
			instr_valid = 1'b1;
			@(posedge clk);
			#1;
			check_value("decoded_valid", 64'(decoded_valid), 64'd1);
			check_value("decoded.imm", decoded.imm, 64'(k + 1));
		end
		instr_valid = 1'b0;
		@(posedge clk);
		#1;
		check_value("decoded_valid", 64'(decoded_valid), 64'd0);
		finish_test("reset and latency");
	endtask

	task automatic classification_test();
		classify_case(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, op_reg), mn_add, r_fmt);
		classify_case(r_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, op_reg), mn_sub, r_fmt);
		classify_case(i_word(12'hfff, 5'd6, 3'd0, 5'd5, op_imm), mn_addi, i_fmt);
		classify_case(i_word({6'h10, 6'd33}, 5'd6, 3'd5, 5'd5, op_imm), mn_srai, i_fmt);
		classify_case(i_word(12'h7f8, 5'd2, 3'd3, 5'd8, op_load), mn_ld, i_fmt);
		classify_case(s_word(12'h008, 5'd7, 5'd2, 3'd2, op_store), mn_sw, s_fmt);
		classify_case(b_word(13'h010, 5'd2, 5'd1, 3'd1, op_branch), mn_bne, b_fmt);
		classify_case(u_word(20'h80001, 5'd9, op_lui), mn_lui, u_fmt);
		classify_case(u_word(20'h00042, 5'd9, op_auipc), mn_auipc, u_fmt);
		classify_case(j_word(21'h000800, 5'd1, op_jal), mn_jal, j_fmt);
		classify_case(i_word(12'h001, 5'd1, 3'd0, 5'd2, op_imm_32), mn_addiw, i_fmt);
		classify_case(r_word(7'h20, 5'd3, 5'd1, 3'd5, 5'd2, op_imm_32), mn_sraiw, i_fmt);
		classify_case(r_word(7'h20, 5'd4, 5'd1, 3'd0, 5'd2, op_reg_32), mn_subw, r_fmt);
		classify_case(r_word(7'h01, 5'd4, 5'd1, 3'd0, 5'd2, op_reg), mn_mul, r_fmt);
		classify_case(r_word(7'h01, 5'd4, 5'd1, 3'd7, 5'd2, op_reg_32), mn_remuw, r_fmt);
		classify_case(i_word(12'h0ff, 5'd0, 3'd0, 5'd0, op_misc_mem), mn_fence, i_fmt);
		classify_case(32'h0000_0073, mn_scall, i_fmt);
		classify_case(32'h0010_0073, mn_sbreak, i_fmt);
		classify_case(i_word(12'hc00, 5'd0, 3'd2, 5'd5, op_system), mn_rdcycle, i_fmt);
		classify_case(i_word(12'hc82, 5'd0, 3'd2, 5'd4, op_system), mn_rdinstreth, i_fmt);
		finish_test("classification");
	endtask

	task automatic flags_test();
		flags_case(i_word(12'h004, 5'd2, 3'd4, 5'd5, op_load), mn_lbu,
			make_flags(5'b11000, sk_plain));
		flags_case(s_word(12'h018, 5'd6, 5'd2, 3'd3, op_store), mn_sd,
			make_flags(5'b01001, sk_plain));
		flags_case(r_word(7'h20, 5'd4, 5'd3, 3'd5, 5'd2, op_reg_32), mn_sraw,
			make_flags(5'b00101, sk_plain));
		flags_case(i_word({6'h10, 6'd40}, 5'd1, 3'd5, 5'd1, op_imm), mn_srai,
			make_flags(5'b00101, sk_plain));
		flags_case(i_word(12'h000, 5'd1, 3'd0, 5'd0, op_jalr), mn_jalr,
			make_flags(5'b00011, sk_link));
		flags_case(i_word(12'hc01, 5'd0, 3'd2, 5'd7, op_system), mn_rdtime,
			make_flags(5'b00011, sk_counter));
		flags_case(i_word(12'h000, 5'd0, 3'd1, 5'd0, op_misc_mem), mn_fence_i,
			make_flags(5'b00011, sk_plain));
		flags_case(r_word(7'h00, 5'd2, 5'd1, 3'd3, 5'd3, op_reg), mn_sltu,
			make_flags(5'b00000, sk_plain));
		flags_case(r_word(7'h01, 5'd2, 5'd1, 3'd2, 5'd3, op_reg), mn_mulhsu,
			make_flags(5'b00000, sk_plain));
		flags_case(b_word(13'h020, 5'd2, 5'd1, 3'd7, op_branch), mn_bgeu,
			make_flags(5'b00000, sk_plain));
		flags_case(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, op_reg), mn_add,
			make_flags(5'b00001, sk_plain));
		finish_test("flags");
	endtask

	task automatic immediate_test();
		logic [11:0] imm12;
		logic [12:0] imm13;
		logic [19:0] imm20;
		logic [20:0] imm21;
		int n;
		for (n = 0; n < 20; n++)
		begin
			rnd = $urandom;
			imm12 = rnd[11:0];
			imm_case(i_word(imm12, 5'd1, 3'd0, 5'd2, op_imm), sign_extend(64'(imm12), 12));
			imm_case(s_word(imm12, 5'd3, 5'd4, 3'd3, op_store), sign_extend(64'(imm12), 12));
			imm13 = {rnd[24:13], 1'b0};
			imm_case(b_word(imm13, 5'd5, 5'd6, 3'd0, op_branch), sign_extend(64'(imm13), 13));
			imm20 = rnd[31:12];
			imm_case(u_word(imm20, 5'd5, op_lui), sign_extend(64'({imm20, 12'd0}), 32));
			rnd = $urandom;
			imm21 = {rnd[20:1], 1'b0};
			imm_case(j_word(imm21, 5'd1, op_jal), sign_extend(64'(imm21), 21));
		end
		finish_test("immediates");
	endtask

	task automatic register_test();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		int n;
		for (n = 0; n < 12; n++)
		begin
			rnd = $urandom;
			rd = rnd[4:0];
			rs1 = rnd[9:5];
			rs2 = rnd[14:10];
			register_case(r_word(7'h00, rs2, rs1, 3'd0, rd, op_reg), r_fmt, rd, rs1, rs2);
			register_case(i_word(rnd[31:20], rs1, 3'd0, rd, op_imm), i_fmt, rd, rs1, rs2);
			register_case(s_word(rnd[31:20], rs2, rs1, 3'd3, op_store), s_fmt, rd, rs1, rs2);
			register_case(b_word({rnd[31:20], 1'b0}, rs2, rs1, 3'd1, op_branch), b_fmt,
				rd, rs1, rs2);
			register_case(u_word(rnd[31:12], rd, op_auipc), u_fmt, rd, rs1, rs2);
			register_case(j_word({rnd[31:12], 1'b0}, rd, op_jal), j_fmt, rd, rs1, rs2);
		end
		finish_test("register fields");
	endtask

	task automatic unknown_test();
		int n;
		for (n = 0; n < 24; n++)
		begin
			rnd = $urandom;
			while (rnd[6:0] inside {op_load, op_store, op_branch, op_jal, op_jalr, op_lui,
				op_auipc, op_imm, op_imm_32, op_reg, op_reg_32, op_misc_mem, op_system})
				rnd = $urandom;
			apply_word(rnd);
			check_value("decoded.op", 64'(decoded.op), 64'(op_unknown));
			check_value("decoded.fmt", 64'(decoded.fmt), 64'(unknown_fmt));
			check_value("decoded.flags", 64'(decoded.flags), 64'd0);
			check_value("decoded.used",
				64'({decoded.rd_used, decoded.rs1_used, decoded.rs2_used}), 64'd0);
		end
		finish_test("unknown words");
	endtask

	initial
	begin
		reset = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		rnd = $urandom(32'h8f5b48a0); // Seeds the generator.
		reset_latency_test();
		classification_test();
		flags_test();
		immediate_test();
		register_test();
		unknown_test();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, total_errors);
		if (failed_tests == 0 && dut_i.assertions_i.fail_count == assert_seen)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* filelist.f */
hdl/riscv_isa_pkg.sv
hdl/decode_pkg.sv
hdl/instruction_classifier.sv
hdl/operand_extractor.sv
hdl/decode_stage.sv
dv/decode_stage_assertions.sv
dv/decode_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module decode_stage_tb \
	-f filelist.f \
	-Mdir obj_dir -o decode_stage_sim

# Keep running past assertion errors so the testbench can report them.
./obj_dir/decode_stage_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail"
	exit 1
fi
